//--- ahb_crypto_pkg.sv
`default_nettype none

package ahb_crypto_pkg;

    // Address bits decoded inside the slave window
    localparam int OFFSET_WIDTH = 10;

    // Register offsets within the window
    localparam logic [OFFSET_WIDTH-1:0] KEY_OFFSET   = 10'h080;
    localparam logic [OFFSET_WIDTH-1:0] NONCE_OFFSET = 10'h100;
    localparam logic [OFFSET_WIDTH-1:0] DEST_OFFSET  = 10'h180;
    localparam logic [OFFSET_WIDTH-1:0] PLAIN_OFFSET = 10'h200;

    // HTRANS encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // HBURST encodings
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_t;

    // Register select, REG_NONE for no access
    typedef enum logic [2:0] {
        REG_NONE,
        REG_KEY,
        REG_NONCE,
        REG_DEST,
        REG_PLAIN
    } reg_sel_t;

    // Offset to register, REG_NONE for unmapped offsets
    function automatic reg_sel_t decode_offset(input logic [OFFSET_WIDTH-1:0] offset);
        reg_sel_t sel;
        case (offset)
            KEY_OFFSET:   sel = REG_KEY;
            NONCE_OFFSET: sel = REG_NONCE;
            DEST_OFFSET:  sel = REG_DEST;
            PLAIN_OFFSET: sel = REG_PLAIN;
            default:      sel = REG_NONE;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

//--- crypto_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module crypto_reg_file #(
    parameter int DATA_WIDTH = 128
) (
    input  wire                             HCLK,
    input  wire                             HRESETn,
    input  wire                             reg_we,
    input  wire ahb_crypto_pkg::reg_sel_t   wr_sel,
    input  wire [DATA_WIDTH-1:0]            HWDATA,
    input  wire ahb_crypto_pkg::reg_sel_t   rd_sel,
    output logic [DATA_WIDTH-1:0]           rd_data
);

    // Crypto engine registers
    logic [DATA_WIDTH-1:0] key_q;
    logic [DATA_WIDTH-1:0] nonce_q;
    logic [DATA_WIDTH-1:0] dest_q;
    logic [DATA_WIDTH-1:0] plain_q;

    // One register per strobe, taken from the bus write data
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            // All registers start at zero
            key_q   <= '0;
            nonce_q <= '0;
            dest_q  <= '0;
            plain_q <= '0;
        end
        else if (reg_we)
        begin
            case (wr_sel)
                ahb_crypto_pkg::REG_KEY:
                    key_q <= HWDATA;
                ahb_crypto_pkg::REG_NONCE:
                    nonce_q <= HWDATA;
                ahb_crypto_pkg::REG_DEST:
                    dest_q <= HWDATA;
                ahb_crypto_pkg::REG_PLAIN:
                    plain_q <= HWDATA;
                // Strobe without a target, nothing written
                default:
                    ;
            endcase
        end
    end

    // Read mux, zero when nothing is selected
    always_comb
    begin
        case (rd_sel)
            ahb_crypto_pkg::REG_KEY:
                rd_data = key_q;
            ahb_crypto_pkg::REG_NONCE:
                rd_data = nonce_q;
            ahb_crypto_pkg::REG_DEST:
                rd_data = dest_q;
            ahb_crypto_pkg::REG_PLAIN:
                rd_data = plain_q;
            default:
                rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- slave_write.sv
`timescale 1ns/1ps
`default_nettype none

module slave_write #(
    parameter int DATA_WIDTH = 128,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                             HCLK,
    input  wire                             HRESETn,
    input  wire                             HSEL,
    input  wire [ADDR_WIDTH-1:0]            HADDR,
    input  wire ahb_crypto_pkg::hburst_t    HBURST,
    input  wire ahb_crypto_pkg::htrans_t    HTRANS,
    input  wire                             HWRITE,
    input  wire                             HREADY,
    input  wire [DATA_WIDTH-1:0]            HWDATA,
    input  wire                             fifo_full,
    output logic                            wr_error,
    output logic                            wr_stall,
    output logic                            reg_we,
    output ahb_crypto_pkg::reg_sel_t        wr_sel,
    output logic                            fifo_push,
    output logic [DATA_WIDTH-1:0]           fifo_data
);

    // Write path states
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_WAIT
    } wr_state_t;

    wr_state_t                  state;
    logic                       addr_valid;
    ahb_crypto_pkg::reg_sel_t   addr_sel;
    logic                       addr_legal;
    logic                       legal_q;
    logic                       is_plain;

    // Write address phase, IDLE is ignored
    assign addr_valid = HSEL && HREADY && HWRITE && (HTRANS != ahb_crypto_pkg::IDLE);

    // Decode only the offset bits
    assign addr_sel = ahb_crypto_pkg::decode_offset(HADDR[ahb_crypto_pkg::OFFSET_WIDTH-1:0]);

    // Only a SINGLE NONSEQ to a mapped offset is legal
    assign addr_legal = (HBURST == ahb_crypto_pkg::SINGLE) &&
                        (HTRANS == ahb_crypto_pkg::NONSEQ) &&
                        (addr_sel != ahb_crypto_pkg::REG_NONE);

    // Plain text writes feed the engine FIFO
    assign is_plain = (wr_sel == ahb_crypto_pkg::REG_PLAIN);

    // Data-phase actions from the registered transfer
    always_comb
    begin
        wr_error  = 1'b0;
        wr_stall  = 1'b0;
        reg_we    = 1'b0;
        fifo_push = 1'b0;
        case (state)
            WR_DATA:
            begin
                if (!legal_q)
                begin
                    // Start of the two-cycle error
                    wr_error = 1'b1;
                end
                else if (is_plain && fifo_full)
                begin
                    // FIFO cannot take the word yet
                    wr_stall = 1'b1;
                end
                else
                begin
                    reg_we    = 1'b1;
                    fifo_push = is_plain;
                end
            end
            WR_WAIT:
            begin
                // Hold until the FIFO has room, then write and push together
                if (fifo_full)
                begin
                    wr_stall = 1'b1;
                end
                else
                begin
                    reg_we    = 1'b1;
                    fifo_push = 1'b1;
                end
            end
            default:
                ;
        endcase
    end

    // Word only shown while it is pushed
    assign fifo_data = fifo_push ? HWDATA : '0;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            state   <= WR_IDLE;
            wr_sel  <= ahb_crypto_pkg::REG_NONE;
            legal_q <= 1'b0;
        end
        else if (addr_valid)
        begin
            // New write transfer, data phase next cycle
            state   <= WR_DATA;
            wr_sel  <= addr_sel;
            legal_q <= addr_legal;
        end
        else if (wr_stall)
        begin
            // Keep the select while stretched
            state <= WR_WAIT;
        end
        else
        begin
            state   <= WR_IDLE;
            wr_sel  <= ahb_crypto_pkg::REG_NONE;
            legal_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- slave_read.sv
`timescale 1ns/1ps
`default_nettype none

module slave_read #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                             HCLK,
    input  wire                             HRESETn,
    input  wire                             HSEL,
    input  wire [ADDR_WIDTH-1:0]            HADDR,
    input  wire ahb_crypto_pkg::hburst_t    HBURST,
    input  wire ahb_crypto_pkg::htrans_t    HTRANS,
    input  wire                             HWRITE,
    input  wire                             HREADY,
    output logic                            rd_error,
    output ahb_crypto_pkg::reg_sel_t        rd_sel
);

    logic                       addr_valid;
    ahb_crypto_pkg::reg_sel_t   addr_sel;
    logic                       addr_legal;

    // Read address phase, IDLE is ignored
    assign addr_valid = HSEL && HREADY && !HWRITE && (HTRANS != ahb_crypto_pkg::IDLE);

    // Offset bits only, upper address bits belong to the decoder
    assign addr_sel = ahb_crypto_pkg::decode_offset(HADDR[ahb_crypto_pkg::OFFSET_WIDTH-1:0]);

    // BUSY, SEQ and every burst other than SINGLE are rejected
    assign addr_legal = (HBURST == ahb_crypto_pkg::SINGLE) &&
                        (HTRANS == ahb_crypto_pkg::NONSEQ) &&
                        (addr_sel != ahb_crypto_pkg::REG_NONE);

    // Classification held for exactly the data phase
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            rd_error <= 1'b0;
            rd_sel   <= ahb_crypto_pkg::REG_NONE;
        end
        else if (addr_valid)
        begin
            if (addr_legal)
            begin
                // Zero-wait read of the decoded register
                rd_error <= 1'b0;
                rd_sel   <= addr_sel;
            end
            else
            begin
                // Error pulse, no register is read
                rd_error <= 1'b1;
                rd_sel   <= ahb_crypto_pkg::REG_NONE;
            end
        end
        else
        begin
            // Data phase done or no read pending
            rd_error <= 1'b0;
            rd_sel   <= ahb_crypto_pkg::REG_NONE;
        end
    end

endmodule

`default_nettype wire

//--- ahb_response.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_response #(
    parameter int DATA_WIDTH = 128
) (
    input  wire                             HCLK,
    input  wire                             HRESETn,
    input  wire                             wr_error,
    input  wire                             rd_error,
    input  wire                             wr_stall,
    input  wire ahb_crypto_pkg::reg_sel_t   rd_sel,
    input  wire [DATA_WIDTH-1:0]            rd_data,
    output logic                            HREADYOUT,
    output logic                            HRESP,
    output logic [DATA_WIDTH-1:0]           HRDATA
);

    // Response sequencer states
    typedef enum logic [1:0] {
        RESP_OKAY,
        RESP_ERR1,
        RESP_ERR2
    } resp_state_t;

    resp_state_t state;
    resp_state_t cur_state;

    // An error pulse opens the first error cycle right away
    always_comb
    begin
        if ((state == RESP_OKAY) && (wr_error || rd_error))
            cur_state = RESP_ERR1;
        else
            cur_state = state;
    end

    // ERR1 then ERR2 then back to OKAY
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            state <= RESP_OKAY;
        else if (cur_state == RESP_ERR1)
            state <= RESP_ERR2;
        else
            state <= RESP_OKAY;
    end

    // Low in the first error cycle and while a write is stretched
    assign HREADYOUT = (cur_state != RESP_ERR1) && !wr_stall;

    // ERROR held over both error cycles
    assign HRESP = (cur_state != RESP_OKAY);

    // Read data only in a read data phase
    assign HRDATA = (rd_sel != ahb_crypto_pkg::REG_NONE) ? rd_data : '0;

endmodule

`default_nettype wire

//--- ahb_crypto_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_crypto_slave #(
    parameter int DATA_WIDTH = 128,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                             HCLK,
    input  wire                             HRESETn,
    input  wire                             HSEL,
    input  wire [ADDR_WIDTH-1:0]            HADDR,
    input  wire ahb_crypto_pkg::hburst_t    HBURST,
    input  wire ahb_crypto_pkg::htrans_t    HTRANS,
    input  wire                             HWRITE,
    input  wire [DATA_WIDTH-1:0]            HWDATA,
    input  wire                             HREADY,
    input  wire                             fifo_full,
    output logic                            HREADYOUT,
    output logic                            HRESP,
    output logic [DATA_WIDTH-1:0]           HRDATA,
    output logic                            fifo_push,
    output logic [DATA_WIDTH-1:0]           fifo_data
);

    // Write path results
    logic                       wr_error;
    logic                       wr_stall;
    logic                       reg_we;
    ahb_crypto_pkg::reg_sel_t   wr_sel;

    // Read path results
    logic                       rd_error;
    ahb_crypto_pkg::reg_sel_t   rd_sel;
    logic [DATA_WIDTH-1:0]      rd_data;

    slave_write #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_slave_write (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HBURST    (HBURST),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HREADY    (HREADY),
        .HWDATA    (HWDATA),
        .fifo_full (fifo_full),
        .wr_error  (wr_error),
        .wr_stall  (wr_stall),
        .reg_we    (reg_we),
        .wr_sel    (wr_sel),
        .fifo_push (fifo_push),
        .fifo_data (fifo_data)
    );

    slave_read #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_slave_read (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .HSEL     (HSEL),
        .HADDR    (HADDR),
        .HBURST   (HBURST),
        .HTRANS   (HTRANS),
        .HWRITE   (HWRITE),
        .HREADY   (HREADY),
        .rd_error (rd_error),
        .rd_sel   (rd_sel)
    );

    // Written from HWDATA, read through rd_sel
    crypto_reg_file #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_crypto_reg_file (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .reg_we  (reg_we),
        .wr_sel  (wr_sel),
        .HWDATA  (HWDATA),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

    ahb_response #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ahb_response (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .wr_error  (wr_error),
        .rd_error  (rd_error),
        .wr_stall  (wr_stall),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .HRDATA    (HRDATA)
    );

endmodule

`default_nettype wire

//--- ahb_crypto_slave_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_crypto_slave_assertions (
    input  wire HCLK,
    input  wire HRESETn,
    input  wire HREADYOUT,
    input  wire HRESP,
    input  wire fifo_push,
    input  wire fifo_full
);

    // OKAY and ready while held in reset
    reset_response: assert property (@(posedge HCLK) !HRESETn |-> (HREADYOUT && !HRESP))
        else $error("HREADYOUT or HRESP wrong during reset");

    // First ERROR cycle is always followed by the ready ERROR cycle
    error_sequence: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
        else $error("ERROR response not completed in its second cycle");

    // No push into a full engine FIFO
    push_not_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !(fifo_push && fifo_full))
        else $error("fifo_push while fifo_full is high");

endmodule

bind ahb_crypto_slave ahb_crypto_slave_assertions u_ahb_crypto_slave_assertions (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .fifo_push (fifo_push),
    .fifo_full (fifo_full)
);

`default_nettype wire

//--- tb_ahb_crypto_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_crypto_slave;

    localparam int DATA_WIDTH         = 128;
    localparam int ADDR_WIDTH         = 32;
    localparam int CLK_PERIOD         = 100;
    localparam int RESET_CYCLES       = 10;
    localparam int NUM_TRANSFERS      = 400;
    // Reset reads, writes, read-back and the stalled plain-text write
    localparam int DIRECTED_TRANSFERS = 13;
    // Eight cycles cover one address cycle and up to four data cycles per transfer
    localparam int WATCHDOG_CYCLES    = RESET_CYCLES + (NUM_TRANSFERS + DIRECTED_TRANSFERS) * 8;

    logic                       HCLK;
    logic                       HRESETn;
    logic                       HSEL;
    logic [ADDR_WIDTH-1:0]      HADDR;
    ahb_crypto_pkg::hburst_t    HBURST;
    ahb_crypto_pkg::htrans_t    HTRANS;
    logic                       HWRITE;
    logic [DATA_WIDTH-1:0]      HWDATA;
    logic                       HREADY;
    logic                       fifo_full;
    logic                       HREADYOUT;
    logic                       HRESP;
    logic [DATA_WIDTH-1:0]      HRDATA;
    logic                       fifo_push;
    logic [DATA_WIDTH-1:0]      fifo_data;

    // Model of key, nonce, destination, plain text
    logic [DATA_WIDTH-1:0]      model_regs [0:3];
    logic [15:0]                lfsr_state = 16'd46;

    // Its own ready closes the loop on a single-slave bus
    assign HREADY = HREADYOUT;

    ahb_crypto_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ahb_crypto_slave (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HBURST    (HBURST),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .fifo_full (fifo_full),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .HRDATA    (HRDATA),
        .fifo_push (fifo_push),
        .fifo_data (fifo_data)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [127:0] take_bits(input int n);
        logic [127:0] value;
        logic         fb;
        int           i;
        value = '0;
        for (i = 0; i < n; i++)
        begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value = {value[126:0], fb};
        end
        return value;
    endfunction

    // Model index of a mapped offset or -1 when unmapped
    function automatic int reg_index(input logic [ADDR_WIDTH-1:0] addr);
        int idx;
        case (addr[9:0])
            10'h080: idx = 0;
            10'h100: idx = 1;
            10'h180: idx = 2;
            10'h200: idx = 3;
            default: idx = -1;
        endcase
        return idx;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] offset_addr(input int idx);
        logic [ADDR_WIDTH-1:0] addr;
        case (idx)
            0:       addr = 32'h0000_0080;
            1:       addr = 32'h0000_0100;
            2:       addr = 32'h0000_0180;
            default: addr = 32'h0000_0200;
        endcase
        return addr;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Address phase followed by data cycles until HREADYOUT is high
    task automatic run_transfer(input logic write, input ahb_crypto_pkg::htrans_t trans,
                                input ahb_crypto_pkg::hburst_t burst,
                                input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data, input int full_cycles);
        int                    idx;
        int                    cycle;
        logic                  legal;
        logic                  is_err;
        logic                  done;
        logic                  exp_ready;
        logic                  exp_resp;
        logic                  exp_push;
        logic [DATA_WIDTH-1:0] exp_rdata;
        idx    = reg_index(addr);
        legal  = (trans == ahb_crypto_pkg::NONSEQ) && (burst == ahb_crypto_pkg::SINGLE) &&
                 (idx >= 0);
        is_err = (trans != ahb_crypto_pkg::IDLE) && !legal;
        @(posedge HCLK);
        #1;
        HTRANS    = trans;
        HBURST    = burst;
        HADDR     = addr;
        HWRITE    = write;
        fifo_full = 1'b0;
        @(posedge HCLK);
        #1;
        // Master idles while the data phase runs
        HTRANS = ahb_crypto_pkg::IDLE;
        HBURST = ahb_crypto_pkg::SINGLE;
        HWDATA = data;
        cycle  = 0;
        done   = 1'b0;
        while (!done)
        begin
            fifo_full = (cycle < full_cycles);
            @(negedge HCLK);
            exp_ready = 1'b1;
            exp_resp  = 1'b0;
            exp_push  = 1'b0;
            exp_rdata = '0;
            if (is_err)
            begin
                // ERROR is not ready in its first cycle and ready in its second
                exp_resp  = 1'b1;
                exp_ready = (cycle != 0);
            end
            else if (legal && write && (idx == 3))
            begin
                // Plain text waits out the full FIFO and then pushes
                exp_ready = (cycle >= full_cycles);
                exp_push  = exp_ready;
            end
            else if (legal && !write)
            begin
                exp_rdata = model_regs[idx];
            end
            check_value("HREADYOUT", 128'(HREADYOUT), 128'(exp_ready));
            check_value("HRESP", 128'(HRESP), 128'(exp_resp));
            check_value("HRDATA", HRDATA, exp_rdata);
            check_value("fifo_push", 128'(fifo_push), 128'(exp_push));
            if (exp_push)
                check_value("fifo_data", fifo_data, data);
            done = HREADYOUT;
            if (done && legal && write)
                model_regs[idx] = data;
            cycle++;
            if (!done)
            begin
                @(posedge HCLK);
                #1;
            end
        end
    endtask

    // Mostly legal NONSEQ SINGLE to mapped offsets and otherwise random fields
    task automatic random_transfer();
        logic [127:0]            r;
        logic                    write;
        ahb_crypto_pkg::htrans_t trans;
        ahb_crypto_pkg::hburst_t burst;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   data;
        int                      full_cycles;
        r     = take_bits(1);
        write = r[0];
        r     = take_bits(3);
        trans = ahb_crypto_pkg::NONSEQ;
        if (r[2:0] >= 3'd6)
        begin
            r     = take_bits(2);
            trans = ahb_crypto_pkg::htrans_t'(r[1:0]);
        end
        r     = take_bits(2);
        burst = ahb_crypto_pkg::SINGLE;
        if (r[1:0] == 2'd0)
        begin
            r     = take_bits(3);
            burst = ahb_crypto_pkg::hburst_t'(r[2:0]);
        end
        r = take_bits(3);
        if (r[2:0] != 3'd0)
        begin
            r    = take_bits(2);
            addr = offset_addr(int'(r[1:0]));
            // Upper bits are outside the decoded window
            r    = take_bits(22);
            addr[31:10] = r[21:0];
        end
        else
        begin
            r    = take_bits(32);
            addr = r[31:0];
        end
        data        = take_bits(128);
        r           = take_bits(2);
        full_cycles = int'(r[1:0]);
        run_transfer(write, trans, burst, addr, data, full_cycles);
    endtask

    initial
    begin
        logic [DATA_WIDTH-1:0] word;
        int                    i;
        HRESETn   = 1'b0;
        HSEL      = 1'b0;
        HADDR     = '0;
        HBURST    = ahb_crypto_pkg::SINGLE;
        HTRANS    = ahb_crypto_pkg::IDLE;
        HWRITE    = 1'b0;
        HWDATA    = '0;
        fifo_full = 1'b0;
        for (i = 0; i < 4; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        HSEL    = 1'b1;
        @(negedge HCLK);
        check_value("HREADYOUT", 128'(HREADYOUT), 128'(1'b1));
        check_value("fifo_push", 128'(fifo_push), 128'(1'b0));
        // Registers come out of reset as zero
        for (i = 0; i < 4; i++)
            run_transfer(1'b0, ahb_crypto_pkg::NONSEQ, ahb_crypto_pkg::SINGLE,
                         offset_addr(i), '0, 0);
        for (i = 0; i < 4; i++)
        begin
            word = take_bits(128);
            run_transfer(1'b1, ahb_crypto_pkg::NONSEQ, ahb_crypto_pkg::SINGLE,
                         offset_addr(i), word, 0);
        end
        for (i = 0; i < 4; i++)
            run_transfer(1'b0, ahb_crypto_pkg::NONSEQ, ahb_crypto_pkg::SINGLE,
                         offset_addr(i), '0, 0);
        // Plain text held off by three full cycles
        word = take_bits(128);
        run_transfer(1'b1, ahb_crypto_pkg::NONSEQ, ahb_crypto_pkg::SINGLE,
                     offset_addr(3), word, 3);
        for (i = 0; i < NUM_TRANSFERS; i++)
            random_transfer();
        $display("SIMULATION PASSED");
        $finish;
    end

    // Bound on the whole run
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the transfers did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- build.f
ahb_crypto_pkg.sv
crypto_reg_file.sv
slave_write.sv
slave_read.sv
ahb_response.sv
ahb_crypto_slave.sv
ahb_crypto_slave_assertions.sv
tb_ahb_crypto_slave.sv

//--- run.sh
#!/bin/sh
# Build and run the AHB crypto slave testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_ahb_crypto_slave

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/Vtb_ahb_crypto_slave > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Run failed"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "Run ended without a result"
    exit 1
fi
echo "Run passed"
